//--- Bender.yml
package:
  name: rename_unit

sources:
  # Packages first, then the design bottom up
  - hw/core_params_pkg.sv
  - hw/rename_types_pkg.sv
  - hw/maptable.sv
  - hw/free_list.sv
  - hw/rename_rob.sv
  - hw/rename_unit.sv
  - target: test
    files:
      - sim/rename_unit_assertions.sv
      - sim/rename_unit_tb.sv

//--- hw/core_params_pkg.sv
package core_params_pkg;

   ////////////////////////////////////////////////////////////
   // Register files and ROB sizing
   ////////////////////////////////////////////////////////////

   localparam int arf_num      = 32;
   localparam int arf_width    = 5;
   localparam int prf_num      = 64;
   localparam int prf_width    = 6;
   localparam int rob_depth    = 16;
   localparam int rob_width    = 4;
   localparam int rename_width = 2;   // Instructions renamed per cycle

   ////////////////////////////////////////////////////////////
   // Index types
   ////////////////////////////////////////////////////////////

   typedef logic [arf_width-1:0] arf_id_t;   // Architectural register
   typedef logic [prf_width-1:0] prf_id_t;   // Physical register
   typedef logic [rob_width-1:0] rob_idx_t;  // ROB slot, wraps at rob_depth

endpackage

//--- hw/free_list.sv
module free_list (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         alloc_req [core_params_pkg::rename_width],
   input  rename_types_pkg::walk_slot_t releases  [2*core_params_pkg::rename_width],
   output core_params_pkg::prf_id_t     alloc_prf [core_params_pkg::rename_width],
   output logic                         two_free
);

   logic [core_params_pkg::prf_num-1:0] free_map;
   logic [core_params_pkg::prf_num-1:0] free_next;

   ////////////////////////////////////////////////////////////
   // Pickers from opposite ends of the bitmap
   ////////////////////////////////////////////////////////////

   always_comb begin
      alloc_prf[0] = '0;
      alloc_prf[1] = '0;
      // Downward scan leaves the lowest free bit
      for (int i = core_params_pkg::prf_num - 1; i >= 0; i--) begin
         if (free_map[i]) alloc_prf[0] = core_params_pkg::prf_id_t'(i);
      end
      for (int i = 0; i < core_params_pkg::prf_num; i++) begin
         if (free_map[i]) alloc_prf[1] = core_params_pkg::prf_id_t'(i);
      end
   end

   always_comb begin
      free_next = free_map;
      for (int i = 0; i < 2 * core_params_pkg::rename_width; i++) begin
         if (releases[i].valid) free_next[releases[i].prf_id] = 1'b1;
      end
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         if (alloc_req[i]) free_next[alloc_prf[i]] = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         // Upper half free, lower half holds the identity map
         free_map <= {{(core_params_pkg::prf_num - core_params_pkg::arf_num){1'b1}},
                      {core_params_pkg::arf_num{1'b0}}};
         two_free <= 1'b0;
      end else begin
         free_map <= free_next;
         two_free <= ($countones(free_next) >= 2);
      end
   end

endmodule

//--- hw/maptable.sv
module maptable (
   input  logic                           clk,
   input  logic                           reset_n,
   input  rename_types_pkg::rename_slot_t rename_in [core_params_pkg::rename_width],
   input  logic                           accept    [core_params_pkg::rename_width],
   input  core_params_pkg::prf_id_t       alloc_prf [core_params_pkg::rename_width],
   input  rename_types_pkg::retire_slot_t retire    [core_params_pkg::rename_width],
   input  rename_types_pkg::walk_slot_t   walk      [core_params_pkg::rename_width],
   input  rename_types_pkg::rob_state_t   rob_state,
   output core_params_pkg::prf_id_t       src_prf   [2*core_params_pkg::rename_width],
   output core_params_pkg::prf_id_t       prd_old   [core_params_pkg::rename_width]
);

   core_params_pkg::prf_id_t spec      [core_params_pkg::arf_num];
   core_params_pkg::prf_id_t spec_next [core_params_pkg::arf_num];
   core_params_pkg::prf_id_t arch      [core_params_pkg::arf_num];
   core_params_pkg::prf_id_t arch_next [core_params_pkg::arf_num];
   logic                     wr0;
   logic                     wr1;

   assign wr0 = accept[0] && rename_in[0].rd_valid;
   assign wr1 = accept[1] && rename_in[1].rd_valid;

   ////////////////////////////////////////////////////////////
   // Reads, with slot 0 bypassed into slot 1
   ////////////////////////////////////////////////////////////

   always_comb begin
      src_prf[0] = spec[rename_in[0].rs1_id];
      src_prf[1] = spec[rename_in[0].rs2_id];
      src_prf[2] = (wr0 && rename_in[1].rs1_id == rename_in[0].rd_id) ?
                   alloc_prf[0] : spec[rename_in[1].rs1_id];
      src_prf[3] = (wr0 && rename_in[1].rs2_id == rename_in[0].rd_id) ?
                   alloc_prf[0] : spec[rename_in[1].rs2_id];
      prd_old[0] = spec[rename_in[0].rd_id];
      // Same rd in one group: slot 1 replaces slot 0's fresh register
      prd_old[1] = (wr0 && rename_in[1].rd_id == rename_in[0].rd_id) ?
                   alloc_prf[0] : spec[rename_in[1].rd_id];
   end

   ////////////////////////////////////////////////////////////
   // Speculative table
   ////////////////////////////////////////////////////////////

   // Slot 1 is written last so it wins a double write
   always_comb begin
      spec_next = spec;
      if (rob_state == rename_types_pkg::rob_walk) begin
         if (walk[0].valid) spec_next[walk[0].arf_id] = walk[0].prf_id;
         if (walk[1].valid) spec_next[walk[1].arf_id] = walk[1].prf_id;
      end else begin
         if (wr0) spec_next[rename_in[0].rd_id] = alloc_prf[0];
         if (wr1) spec_next[rename_in[1].rd_id] = alloc_prf[1];
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < core_params_pkg::arf_num; i++) begin
            spec[i] <= core_params_pkg::prf_id_t'(i);   // Identity map
         end
      end else if (rob_state == rename_types_pkg::rob_rollback) begin
         spec <= arch;
      end else begin
         spec <= spec_next;
      end
   end

   ////////////////////////////////////////////////////////////
   // Retirement table
   ////////////////////////////////////////////////////////////

   always_comb begin
      arch_next = arch;
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         if (retire[i].valid && retire[i].wb) begin
            arch_next[retire[i].arf_id] = retire[i].prf_id;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < core_params_pkg::arf_num; i++) begin
            arch[i] <= core_params_pkg::prf_id_t'(i);
         end
      end else begin
         arch <= arch_next;   // Keeps retiring during walk too
      end
   end

endmodule

//--- hw/rename_rob.sv
module rename_rob (
   input  logic                             clk,
   input  logic                             reset_n,
   input  logic                             accept    [core_params_pkg::rename_width],
   input  rename_types_pkg::rename_slot_t   rename_in [core_params_pkg::rename_width],
   input  rename_types_pkg::rename_result_t result    [core_params_pkg::rename_width],
   input  logic                             complete_valid,
   input  core_params_pkg::rob_idx_t        complete_idx,
   input  logic                             mispredict_valid,
   input  core_params_pkg::rob_idx_t        mispredict_idx,
   output core_params_pkg::rob_idx_t        rob_idx     [core_params_pkg::rename_width],
   output logic                             room,
   output rename_types_pkg::retire_slot_t   retire      [core_params_pkg::rename_width],
   output rename_types_pkg::walk_slot_t     walk        [core_params_pkg::rename_width],
   output rename_types_pkg::walk_slot_t     squash_free [core_params_pkg::rename_width],
   output rename_types_pkg::rob_state_t     rob_state
);

   // Entry storage
   logic                      ent_rd_valid [core_params_pkg::rob_depth];
   core_params_pkg::arf_id_t  ent_rd_id    [core_params_pkg::rob_depth];
   core_params_pkg::prf_id_t  ent_prd      [core_params_pkg::rob_depth];
   core_params_pkg::prf_id_t  ent_prd_old  [core_params_pkg::rob_depth];
   logic                      ent_done     [core_params_pkg::rob_depth];

   core_params_pkg::rob_idx_t head, tail;
   core_params_pkg::rob_idx_t branch_idx;   // Surviving mispredicted branch
   core_params_pkg::rob_idx_t walk_ptr;
   core_params_pkg::rob_idx_t br_off, sq_left;
   logic [core_params_pkg::rob_width:0] count;
   logic [core_params_pkg::rob_width:0] keep;        // Retirable survivors
   logic [core_params_pkg::rob_width:0] walk_left;
   logic [core_params_pkg::rob_width:0] mkeep, lim;
   logic [1:0] acc_cnt, ret_cnt, pop_cnt, walk_cnt, pend;
   logic       ret0, ret1, pop0, pop1, w0, w1;

   ////////////////////////////////////////////////////////////
   // Allocation and retire selection
   ////////////////////////////////////////////////////////////

   always_comb begin
      rob_idx[0] = tail;
      rob_idx[1] = accept[0] ? tail + 1'b1 : tail;
      acc_cnt    = {1'b0, accept[0]} + {1'b0, accept[1]};
      room       = (count <= core_params_pkg::rob_depth - 2);

      // Nothing past the branch may retire once it has mispredicted
      br_off = mispredict_idx - head;
      mkeep  = {1'b0, br_off} + 1'b1;
      if (rob_state == rename_types_pkg::rob_idle) lim = mispredict_valid ? mkeep : count;
      else lim = keep;
      ret0    = (lim >= 1) && ent_done[head];
      ret1    = ret0 && (lim >= 2) && ent_done[head + 1'b1];
      ret_cnt = {1'b0, ret0} + {1'b0, ret1};
      pend    = {1'b0, retire[0].valid} + {1'b0, retire[1].valid};   // Not yet in arch table
   end

   ////////////////////////////////////////////////////////////
   // Squash pops and walk replay
   ////////////////////////////////////////////////////////////

   always_comb begin
      sq_left  = tail - branch_idx - 1'b1;
      pop0     = (rob_state == rename_types_pkg::rob_squash) && (sq_left >= 1);
      pop1     = (rob_state == rename_types_pkg::rob_squash) && (sq_left >= 2);
      pop_cnt  = {1'b0, pop0} + {1'b0, pop1};
      w0       = (rob_state == rename_types_pkg::rob_walk) && (walk_left >= 1);
      w1       = (rob_state == rename_types_pkg::rob_walk) && (walk_left >= 2);
      walk_cnt = {1'b0, w0} + {1'b0, w1};

      squash_free[0] = '{valid: pop0 && ent_rd_valid[tail - 1'b1],
                         arf_id: ent_rd_id[tail - 1'b1], prf_id: ent_prd[tail - 1'b1]};
      squash_free[1] = '{valid: pop1 && ent_rd_valid[tail - 2'd2],
                         arf_id: ent_rd_id[tail - 2'd2], prf_id: ent_prd[tail - 2'd2]};
      walk[0] = '{valid: w0 && ent_rd_valid[walk_ptr],
                  arf_id: ent_rd_id[walk_ptr], prf_id: ent_prd[walk_ptr]};
      walk[1] = '{valid: w1 && ent_rd_valid[walk_ptr + 1'b1],
                  arf_id: ent_rd_id[walk_ptr + 1'b1], prf_id: ent_prd[walk_ptr + 1'b1]};
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         if (accept[i]) begin
            ent_rd_valid[rob_idx[i]] <= rename_in[i].rd_valid;
            ent_rd_id[rob_idx[i]]    <= rename_in[i].rd_id;
            ent_prd[rob_idx[i]]      <= result[i].prd;
            ent_prd_old[rob_idx[i]]  <= result[i].prd_old;
            ent_done[rob_idx[i]]     <= 1'b0;
         end
      end
      if (complete_valid) ent_done[complete_idx] <= 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Pointers, retire register and recovery FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rob_state  <= rename_types_pkg::rob_idle;
         head       <= '0;
         tail       <= '0;
         count      <= '0;
         keep       <= '0;
         walk_ptr   <= '0;
         walk_left  <= '0;
         branch_idx <= '0;
         retire[0]  <= '0;
         retire[1]  <= '0;
      end else begin
         head  <= head + ret_cnt;
         tail  <= tail + acc_cnt - pop_cnt;
         count <= count + acc_cnt - ret_cnt - pop_cnt;
         keep  <= lim - ret_cnt;
         retire[0] <= '{valid: ret0, wb: ent_rd_valid[head], arf_id: ent_rd_id[head],
                        prf_id: ent_prd[head], prf_old: ent_prd_old[head]};
         retire[1] <= '{valid: ret1, wb: ent_rd_valid[head + 1'b1],
                        arf_id: ent_rd_id[head + 1'b1], prf_id: ent_prd[head + 1'b1],
                        prf_old: ent_prd_old[head + 1'b1]};
         case (rob_state)
            rename_types_pkg::rob_idle: begin
               if (mispredict_valid) begin
                  rob_state  <= rename_types_pkg::rob_squash;
                  branch_idx <= mispredict_idx;
               end
            end
            rename_types_pkg::rob_squash: begin
               if (sq_left <= 2) rob_state <= rename_types_pkg::rob_rollback;
            end
            rename_types_pkg::rob_rollback: begin
               // Walk from the oldest entry the arch table still lacks
               rob_state <= rename_types_pkg::rob_walk;
               walk_ptr  <= head - pend;
               walk_left <= keep + pend;
            end
            default: begin
               walk_ptr  <= walk_ptr + walk_cnt;
               walk_left <= walk_left - walk_cnt;
               if (walk_left <= 2) rob_state <= rename_types_pkg::rob_idle;
            end
         endcase
      end
   end

endmodule

//--- hw/rename_types_pkg.sv
package rename_types_pkg;

   // One instruction entering rename
   typedef struct packed {
      logic                     valid;
      logic                     rd_valid;
      core_params_pkg::arf_id_t rd_id;
      core_params_pkg::arf_id_t rs1_id;
      core_params_pkg::arf_id_t rs2_id;
   } rename_slot_t;

   // Rename outcome handed downstream
   typedef struct packed {
      core_params_pkg::prf_id_t  prf_rs1;
      core_params_pkg::prf_id_t  prf_rs2;
      core_params_pkg::prf_id_t  prd;       // New mapping of rd
      core_params_pkg::prf_id_t  prd_old;   // Mapping it replaces
      core_params_pkg::rob_idx_t rob_idx;
   } rename_result_t;

   typedef struct packed {
      logic                     valid;
      logic                     wb;        // Entry wrote a destination
      core_params_pkg::arf_id_t arf_id;
      core_params_pkg::prf_id_t prf_id;
      core_params_pkg::prf_id_t prf_old;
   } retire_slot_t;

   // Replayed write, also reused for register releases
   typedef struct packed {
      logic                     valid;
      core_params_pkg::arf_id_t arf_id;
      core_params_pkg::prf_id_t prf_id;
   } walk_slot_t;

   ////////////////////////////////////////////////////////////
   // Recovery sequence
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      rob_idle,
      rob_squash,     // Pop younger entries from the tail
      rob_rollback,   // Speculative table loads retirement table
      rob_walk        // Replay survivors oldest first
   } rob_state_t;

endpackage

//--- hw/rename_unit.sv
module rename_unit (
   input  logic                             clk,
   input  logic                             reset_n,
   input  rename_types_pkg::rename_slot_t   rename_in  [core_params_pkg::rename_width],
   output logic                             rename_ready,
   output rename_types_pkg::rename_result_t rename_out [core_params_pkg::rename_width],
   input  logic                             complete_valid,
   input  core_params_pkg::rob_idx_t        complete_idx,
   input  logic                             mispredict_valid,
   input  core_params_pkg::rob_idx_t        mispredict_idx,
   output rename_types_pkg::retire_slot_t   retire_out [core_params_pkg::rename_width]
);

   logic                         accept      [core_params_pkg::rename_width];
   logic                         alloc_req   [core_params_pkg::rename_width];
   core_params_pkg::prf_id_t     alloc_prf   [core_params_pkg::rename_width];
   core_params_pkg::prf_id_t     src_prf     [2*core_params_pkg::rename_width];
   core_params_pkg::prf_id_t     prd_old     [core_params_pkg::rename_width];
   core_params_pkg::rob_idx_t    rob_idx     [core_params_pkg::rename_width];
   rename_types_pkg::walk_slot_t walk        [core_params_pkg::rename_width];
   rename_types_pkg::walk_slot_t squash_free [core_params_pkg::rename_width];
   rename_types_pkg::walk_slot_t releases    [2*core_params_pkg::rename_width];
   rename_types_pkg::rob_state_t rob_state;
   logic                         two_free;
   logic                         room;

   // Need two registers and two ROB slots so a full group always fits
   assign rename_ready = (rob_state == rename_types_pkg::rob_idle) && two_free && room;

   always_comb begin
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         accept[i]     = rename_in[i].valid && rename_ready;
         alloc_req[i]  = accept[i] && rename_in[i].rd_valid;
         rename_out[i] = '{prf_rs1: src_prf[2*i], prf_rs2: src_prf[2*i+1],
                           prd: alloc_prf[i], prd_old: prd_old[i], rob_idx: rob_idx[i]};
         releases[i]   = '{valid: retire_out[i].valid && retire_out[i].wb,
                           arf_id: retire_out[i].arf_id, prf_id: retire_out[i].prf_old};
         releases[i + core_params_pkg::rename_width] = squash_free[i];
      end
   end

   maptable u_maptable (
      .clk, .reset_n, .rename_in, .accept, .alloc_prf,
      .retire (retire_out), .walk, .rob_state, .src_prf, .prd_old
   );

   free_list u_free_list (
      .clk, .reset_n, .alloc_req, .releases, .alloc_prf, .two_free
   );

   rename_rob u_rename_rob (
      .clk, .reset_n, .accept, .rename_in, .result (rename_out),
      .complete_valid, .complete_idx, .mispredict_valid, .mispredict_idx,
      .rob_idx, .room, .retire (retire_out), .walk, .squash_free, .rob_state
   );

endmodule

//--- rename_unit.f
hw/core_params_pkg.sv
hw/rename_types_pkg.sv
hw/maptable.sv
hw/free_list.sv
hw/rename_rob.sv
hw/rename_unit.sv
sim/rename_unit_assertions.sv
sim/rename_unit_tb.sv

//--- sim/rename_unit_assertions.sv
module rename_unit_assertions (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         rename_ready,
   input  logic                         mispredict_valid,
   input  logic                         alloc_req [core_params_pkg::rename_width],
   input  core_params_pkg::prf_id_t     alloc_prf [core_params_pkg::rename_width],
   input  rename_types_pkg::rob_state_t rob_state
);

   timeunit 1ns;
   timeprecision 1ps;

   // Recovery starts on the next edge and blocks rename at once
   stall_on_mispredict: assert property (@(posedge clk) disable iff (!reset_n)
      (mispredict_valid && rob_state == rename_types_pkg::rob_idle) |=>
      (rob_state == rename_types_pkg::rob_squash) && !rename_ready)
      else $error("rename was not stalled after a mispredict");

   alloc_distinct: assert property (@(posedge clk) disable iff (!reset_n)
      (alloc_req[0] && alloc_req[1]) |-> (alloc_prf[0] != alloc_prf[1]))
      else $error("both slots were given the same physical register");

   // Table copy takes exactly one cycle
   rollback_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
      (rob_state == rename_types_pkg::rob_rollback) |=>
      (rob_state == rename_types_pkg::rob_walk))
      else $error("rob_rollback did not move to rob_walk after one cycle");

endmodule

bind rename_unit rename_unit_assertions u_rename_unit_assertions (
   .clk, .reset_n, .rename_ready, .mispredict_valid, .alloc_req, .alloc_prf, .rob_state
);

//--- sim/rename_unit_tb.sv
module rename_unit_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int run_cycles  = 2000;
   localparam int stall_limit = 200;   // Cycles rename_ready may stay low
   localparam int drain_limit = 500;

   // One in-flight instruction as the model sees it
   typedef struct packed {
      logic                      rd_valid;
      core_params_pkg::arf_id_t  rd;
      core_params_pkg::prf_id_t  prd;
      core_params_pkg::prf_id_t  prd_old;
      core_params_pkg::rob_idx_t idx;
      logic                      done;
   } entry_t;

   logic                             clk;
   logic                             reset_n;
   rename_types_pkg::rename_slot_t   rename_in  [core_params_pkg::rename_width];
   logic                             rename_ready;
   rename_types_pkg::rename_result_t rename_out [core_params_pkg::rename_width];
   logic                             complete_valid;
   core_params_pkg::rob_idx_t        complete_idx;
   logic                             mispredict_valid;
   core_params_pkg::rob_idx_t        mispredict_idx;
   rename_types_pkg::retire_slot_t   retire_out [core_params_pkg::rename_width];

   core_params_pkg::prf_id_t  spec_map [core_params_pkg::arf_num];
   core_params_pkg::prf_id_t  arch_map [core_params_pkg::arf_num];
   logic                      live     [core_params_pkg::prf_num];   // Allocated, not freed
   entry_t                    inflight [$];                          // Oldest at the front
   core_params_pkg::rob_idx_t tail_idx;                              // Next ROB slot handed out

   logic [31:0] lfsr = 32'h101c3780;
   int          checks;
   int          errors;
   int          mispredicts;
   int          stall;
   bit          recovering;
   bit          check_low;
   bit          last_ready;
   bit          timed_out;

   rename_unit UUT (.*);

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic compare(input int actual, input int expected, input string what);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                  $time, what, actual, expected);
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic core_params_pkg::arf_id_t pick_reg();
      // Half stay in r0..r7 so groups share registers often
      if (next_bits(1) == 1) return core_params_pkg::arf_id_t'(next_bits(3));
      return core_params_pkg::arf_id_t'(next_bits(5));
   endfunction

   // Nothing in flight and the last release has reached the free list
   function automatic bit drained();
      return inflight.size() == 0 && rename_ready &&
             !retire_out[0].valid && !retire_out[1].valid;
   endfunction

   task automatic new_group();
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         rename_in[i].valid    = (next_bits(2) != 0);
         rename_in[i].rd_valid = (next_bits(3) != 0);
         rename_in[i].rd_id    = pick_reg();
         rename_in[i].rs1_id   = pick_reg();
         rename_in[i].rs2_id   = pick_reg();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   task automatic collect_retires();
      entry_t e;
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         if (retire_out[i].valid && inflight.size() == 0) begin
            errors++;
            $display("Retire at %0t ns with no instruction in flight", $time);
         end else if (retire_out[i].valid) begin
            e = inflight.pop_front();
            compare(int'(retire_out[i].wb), int'(e.rd_valid), "retire wb");
            compare(int'(retire_out[i].arf_id), int'(e.rd), "retire arf_id");
            compare(int'(retire_out[i].prf_id), int'(e.prd), "retire prf_id");
            compare(int'(retire_out[i].prf_old), int'(e.prd_old), "retire prf_old");
            compare(int'(e.done), 1, "retired entry was completed");
            if (e.rd_valid) begin
               arch_map[e.rd]  = e.prd;
               live[e.prd_old] = 1'b0;   // Old mapping is dead now
            end
         end
      end
   endtask

   // Slot 0 writes the map before slot 1 reads it, giving bypass and WAW
   task automatic record_renames();
      entry_t e;
      for (int i = 0; i < core_params_pkg::rename_width; i++) begin
         if (rename_in[i].valid) begin
            compare(int'(rename_out[i].prf_rs1), int'(spec_map[rename_in[i].rs1_id]),
                    "prf_rs1 mapping");
            compare(int'(rename_out[i].prf_rs2), int'(spec_map[rename_in[i].rs2_id]),
                    "prf_rs2 mapping");
            compare(int'(rename_out[i].prd_old), int'(spec_map[rename_in[i].rd_id]),
                    "prd_old mapping");
            compare(int'(rename_out[i].rob_idx), int'(tail_idx), "rob_idx");
            e = '{rd_valid: rename_in[i].rd_valid, rd: rename_in[i].rd_id,
                  prd: rename_out[i].prd, prd_old: spec_map[rename_in[i].rd_id],
                  idx: tail_idx, done: 1'b0};
            tail_idx = tail_idx + 1'b1;
            if (e.rd_valid) begin
               compare(int'(live[e.prd]), 0, "new prd is already live");
               live[e.prd]    = 1'b1;
               spec_map[e.rd] = e.prd;
            end
            inflight.push_back(e);
         end
      end
   endtask

   // Drop everything younger than the branch, then rebuild from retired state
   task automatic squash_after(input int pos);
      entry_t e;
      while (inflight.size() > pos + 1) begin
         e = inflight.pop_back();
         if (e.rd_valid) live[e.prd] = 1'b0;
      end
      tail_idx = inflight[pos].idx + 1'b1;   // Slot after the branch
      spec_map = arch_map;
      foreach (inflight[k]) begin
         if (inflight[k].rd_valid) spec_map[inflight[k].rd] = inflight[k].prd;
      end
      recovering = 1'b1;
   endtask

   task automatic run_cycle(input bit gen, input bit allow_mp);
      int pick;
      int j;
      int branch_pos;
      @(negedge clk);
      collect_retires();
      if (!gen) begin
         rename_in[0] = '0;
         rename_in[1] = '0;
      end else if (last_ready || !(rename_in[0].valid || rename_in[1].valid)) begin
         new_group();   // Otherwise hold the stalled group
      end
      complete_valid = 1'b0;
      if (inflight.size() > 0 && next_bits(2) != 0) begin
         pick = int'(next_bits(4)) % inflight.size();
         for (int k = 0; k < inflight.size(); k++) begin
            j = (pick + k) % inflight.size();
            if (!complete_valid && !inflight[j].done) begin
               complete_valid   = 1'b1;
               complete_idx     = inflight[j].idx;
               inflight[j].done = 1'b1;
            end
         end
      end
      mispredict_valid = 1'b0;
      branch_pos       = 0;
      if (allow_mp && !recovering && inflight.size() > 0 && next_bits(5) == 0) begin
         branch_pos       = int'(next_bits(4)) % inflight.size();
         mispredict_valid = 1'b1;
         mispredict_idx   = inflight[branch_pos].idx;
      end
      #1;   // Combinational rename path settled
      if (check_low) compare(int'(rename_ready), 0, "rename_ready during recovery");
      check_low = 1'b0;
      if (rename_ready) begin
         recovering = 1'b0;
         record_renames();
      end
      last_ready = rename_ready;
      if (mispredict_valid) begin
         squash_after(branch_pos);
         mispredicts++;
         check_low = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int err_mark;
      int live_count;
      clk              = 1'b0;
      reset_n          = 1'b0;
      rename_in[0]     = '0;
      rename_in[1]     = '0;
      complete_valid   = 1'b0;
      complete_idx     = '0;
      mispredict_valid = 1'b0;
      mispredict_idx   = '0;
      tail_idx         = '0;
      for (int r = 0; r < core_params_pkg::arf_num; r++) begin
         spec_map[r] = core_params_pkg::prf_id_t'(r);
         arch_map[r] = core_params_pkg::prf_id_t'(r);
      end
      for (int p = 0; p < core_params_pkg::prf_num; p++) live[p] = (p < core_params_pkg::arf_num);

      for (int c = 0; c < 8; c++) begin
         @(negedge clk);
         compare(int'(rename_ready), 0, "rename_ready in reset");
         compare(int'(retire_out[0].valid || retire_out[1].valid), 0, "retire_out in reset");
      end
      reset_n = 1'b1;
      $display("Test reset finished with %0d errors", errors);

      err_mark = errors;
      for (int c = 0; c < run_cycles && !timed_out; c++) begin
         run_cycle(1'b1, 1'b1);
         stall = rename_ready ? 0 : stall + 1;
         if (stall > stall_limit) begin
            timed_out = 1'b1;
            $display("Timeout: rename_ready stayed low for %0d cycles", stall_limit);
         end
      end
      $display("Test random rename finished with %0d mispredicts and %0d errors",
               mispredicts, errors - err_mark);

      if (!timed_out) begin
         err_mark = errors;
         stall    = 0;
         do begin
            run_cycle(1'b0, 1'b0);
            stall++;
         end while (!drained() && stall < drain_limit);
         if (!drained()) begin
            timed_out = 1'b1;
            $display("Timeout: instructions did not drain within %0d cycles", drain_limit);
         end
         live_count = 0;
         foreach (live[p]) live_count += int'(live[p]);
         compare($countones(UUT.u_free_list.free_map), core_params_pkg::prf_num - live_count,
                 "free registers after drain");
         $display("Test drain finished with %0d errors", errors - err_mark);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
